// ==== verification/cache_stim.txt ====
# op addr data sel, all values hex. R read, W write, F flush all.
# data is ignored on R, address, data and sel are ignored on F.
R 00001230 00000000 f
R 00001234 00000000 6
W 00001234 a1b2c3d4 3
W 00001234 55667788 c
R 00001234 00000000 f
W 00001238 deadbeef 5
R 00001238 00000000 f
R 0000123c 00000000 a
W 00020000 11110000 f
W 00020014 22220001 3
W 00020028 33330002 c
W 0002003c 44440003 f
W 00020040 55550004 9
W 00020054 66660005 f
W 00020068 77770006 6
W 0002007c 88880007 f
W 00020080 99990008 1
W 00020094 aaaa0009 f
W 000200a8 bbbb000a e
W 000200bc cccc000b f
W 000200c0 dddd000c 3
W 000200d4 eeee000d f
W 000200e8 ffff000e c
W 000200fc 1234000f f
W 00020100 23450010 f
W 00020114 34560011 5
W 00020128 45670012 f
W 0002013c 56780013 a
W 00020140 67890014 f
W 00020154 789a0015 f
W 00020168 89ab0016 8
W 0002017c 9abc0017 f
W 00020180 abcd0018 2
W 00020194 bcde0019 f
W 000201a8 cdef001a f
W 000201bc def0001b 4
W 000201c0 0f1e001c f
W 000201d4 1e2d001d f
W 000201e8 2d3c001e 7
W 000201fc 3c4b001f f
W 00020200 4b5a0020 f
W 00020214 5a690021 b
W 00020228 69780022 f
W 0002023c 78870023 f
W 00020240 87960024 d
W 00020254 96a50025 f
W 00020268 a5b40026 f
W 0002027c b4c30027 3
R 00020000 00000000 f
R 00020014 00000000 f
R 00020028 00000000 f
R 0002003c 00000000 f
R 00001234 00000000 f
F 00000000 00000000 0
W 00020000 cafef00d f
R 00020000 00000000 3
R 00030010 00000000 f
W 00030010 0badc0de 6
R 00030010 00000000 f
R 00020014 00000000 c
R 00001238 00000000 f
R 000201fc 00000000 f
F 00000000 00000000 0
R 00020028 00000000 f

// ==== sources.f ====
verilog/cache_pkg.sv
verilog/req_fifo.sv
verilog/cache_line.sv
verilog/lru_tracker.sv
verilog/cache_ctrl.sv
verilog/ddr3_cache.sv
verification/tb_ddr3_cache.sv

// ==== Bender.yml ====
package:
  name: ddr3_cache

sources:
  - files:
      - verilog/cache_pkg.sv
      - verilog/req_fifo.sv
      - verilog/cache_line.sv
      - verilog/lru_tracker.sv
      - verilog/cache_ctrl.sv
      - verilog/ddr3_cache.sv

  - target: simulation
    files:
      - verification/tb_ddr3_cache.sv

// ==== verification/tb_ddr3_cache.sv ====
module tb_ddr3_cache;

  import cache_pkg::*;

  localparam int          DRIVE_DLY = 1;
  localparam int          TIMEOUT   = 2000;
  localparam int          CHK_W     = $bits(mem_req_t);
  localparam logic [31:0] SEED      = 32'h4fbed6ff;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  flush_start_i;
  logic                  flush_done_o;
  logic                  bus_cyc_i;
  logic                  bus_stb_i;
  bus_req_t              bus_req_i;
  logic                  bus_stall_o;
  logic                  bus_ack_o;
  logic [BUS_DATA_W-1:0] bus_data_o;
  logic                  dst_cyc_o;
  logic                  dst_stb_o;
  mem_req_t              dst_req_o;
  logic                  dst_stall_i;
  logic                  dst_ack_i;
  line_data_t            dst_data_i;

  // memory model and shadow copy of every byte written on the bus.
  logic [MEM_DATA_W-1:0] mem [logic [27:0]];
  logic [7:0]            shadow [logic [31:0]];
  bus_req_t              pend_q [$];

  logic                  rd_pending = 1'b0;
  logic [27:0]           rd_key;
  int                    rd_wait;
  logic                  held_valid = 1'b0;
  mem_req_t              held_req;

  int errors    = 0;
  int checks    = 0;
  int sent_cnt  = 0;
  int ack_cnt   = 0;
  int rd_total  = 0;
  int wr_total  = 0;
  int flush_cnt = 0;
  int flush_req = 0;

  ddr3_cache dut0 (
    .clk           (clk),
    .rst           (rst),
    .flush_start_i (flush_start_i),
    .flush_done_o  (flush_done_o),
    .bus_cyc_i     (bus_cyc_i),
    .bus_stb_i     (bus_stb_i),
    .bus_req_i     (bus_req_i),
    .bus_stall_o   (bus_stall_o),
    .bus_ack_o     (bus_ack_o),
    .bus_data_o    (bus_data_o),
    .dst_cyc_o     (dst_cyc_o),
    .dst_stb_o     (dst_stb_o),
    .dst_req_o     (dst_req_o),
    .dst_stall_i   (dst_stall_i),
    .dst_ack_i     (dst_ack_i),
    .dst_data_i    (dst_data_i)
  );

  always #2 clk = ~clk;

  task automatic end_run();
    $display("checks %0d, errors %0d, requests %0d, acks %0d, line reads %0d, line writes %0d",
             checks, errors, sent_cnt, ack_cnt, rd_total, wr_total);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [CHK_W-1:0] expected,
                             input logic [CHK_W-1:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  ////////////////////
  // reference values.
  function automatic logic [7:0] pattern_byte(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    w = w ^ {w[15:0], w[31:16]} ^ 32'h3c5a_a5c3;
    return w[8*a[1:0] +: 8];
  endfunction

  function automatic logic [7:0] expect_byte(input logic [31:0] a);
    if (shadow.exists(a))
      return shadow[a];
    return pattern_byte(a);
  endfunction

  function automatic logic [MEM_DATA_W-1:0] mem_line(input logic [27:0] key);
    logic [MEM_DATA_W-1:0] l;
    if (mem.exists(key))
      return mem[key];
    for (int n = 0; n < 16; n++)
      l[8*n +: 8] = pattern_byte({key, 4'(n)});
    return l;
  endfunction

  function automatic logic [MEM_DATA_W-1:0] shadow_line(input logic [27:0] key);
    logic [MEM_DATA_W-1:0] l;
    for (int n = 0; n < 16; n++)
      l[8*n +: 8] = expect_byte({key, 4'(n)});
    return l;
  endfunction

  // unselected bytes are zero.
  function automatic logic [31:0] expect_word(input bus_req_t r);
    logic [31:0] w;
    for (int b = 0; b < 4; b++)
      w[8*b +: 8] = r.sel[b] ? expect_byte({r.addr.raw[31:2], 2'(b)}) : 8'h00;
    return w;
  endfunction

  task automatic apply_write(input bus_req_t r);
    for (int b = 0; b < 4; b++)
    begin
      if (r.sel[b])
        shadow[{r.addr.raw[31:2], 2'(b)}] = r.data[8*b +: 8];
    end
  endtask

  ////////////////////
  // monitors.
  task automatic take_ack();
    bus_req_t r;
    ack_cnt++;
    if (pend_q.size() == 0)
    begin
      errors++;
      $display("bus ack at %0t with no request outstanding", $time);
    end
    else
    begin
      r = pend_q.pop_front();
      if (r.we)
        apply_write(r);
      else
        check_value("bus_data_o", expect_word(r), bus_data_o);
      if (ack_cnt == 1)
        check_value("line reads for first miss", 1, rd_total);
    end
  endtask

  task automatic watch_memory_port();
    logic [27:0] key;
    if (held_valid)
    begin
      check_value("dst_stb_o under stall", 1, dst_stb_o);
      check_value("dst_req_o under stall", held_req, dst_req_o);
    end
    held_valid = dst_stb_o & dst_stall_i;
    held_req   = dst_req_o;
    if (dst_stb_o && !dst_cyc_o)
    begin
      errors++;
      $display("dst_stb_o high without dst_cyc_o at %0t", $time);
    end
    if (dst_stb_o && !dst_stall_i)
    begin
      key = dst_req_o.addr[31:4];
      if (dst_req_o.we)
      begin
        // a written back line must hold every byte acknowledged so far.
        check_value("dst_req_o.data", shadow_line(key), dst_req_o.data);
        mem[key] = dst_req_o.data;
        wr_total++;
      end
      else
      begin
        if (rd_pending)
        begin
          errors++;
          $display("second line read issued at %0t before the first was answered", $time);
        end
        rd_total++;
        rd_pending = 1'b1;
        rd_key     = key;
        rd_wait    = -1;
      end
    end
  endtask

  always @(negedge clk)
  begin
    if (rst === 1'b0)
    begin
      if (bus_ack_o)
        take_ack();
      if (flush_done_o)
        flush_cnt++;
      watch_memory_port();
    end
  end

  // memory responder.
  initial
  begin
    void'($urandom(SEED));
    forever
    begin
      @(posedge clk);
      #DRIVE_DLY;
      dst_stall_i = ($urandom % 3) == 0;
      dst_ack_i   = 1'b0;
      if (rd_pending)
      begin
        if (rd_wait < 0)
          rd_wait = $urandom % 5;
        if (rd_wait == 0)
        begin
          dst_ack_i  = 1'b1;
          dst_data_i = mem_line(rd_key);
          rd_pending = 1'b0;
        end
        else
          rd_wait--;
      end
    end
  end

  ////////////////////
  // stimulus.
  task automatic check_idle_outputs();
    check_value("bus_ack_o", 0, bus_ack_o);
    check_value("dst_stb_o", 0, dst_stb_o);
    check_value("dst_cyc_o", 0, dst_cyc_o);
    check_value("flush_done_o", 0, flush_done_o);
    check_value("bus_stall_o", 0, bus_stall_o);
  endtask

  task automatic send_request(input bus_req_t r);
    int waited;
    waited    = 0;
    bus_cyc_i = 1'b1;
    bus_stb_i = 1'b1;
    bus_req_i = r;
    @(negedge clk);
    while (bus_stall_o)
    begin
      waited++;
      if (waited > TIMEOUT)
      begin
        errors++;
        $display("timeout, the cache never took a request at %0t", $time);
        end_run();
      end
      @(negedge clk);
    end
    pend_q.push_back(r);
    sent_cnt++;
    @(posedge clk);
    #DRIVE_DLY;
    bus_cyc_i = 1'b0;
    bus_stb_i = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (ack_cnt < sent_cnt)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
      if (waited > TIMEOUT)
      begin
        errors++;
        $display("timeout, %0d requests still wait for an ack", sent_cnt - ack_cnt);
        end_run();
      end
    end
  endtask

  task automatic compare_memory();
    foreach (shadow[a])
    begin
      if (!mem.exists(a[31:4]))
      begin
        errors++;
        $display("line %h was written on the bus but never reached memory", a[31:4]);
      end
    end
    foreach (mem[k])
      check_value($sformatf("memory line %h", k), shadow_line(k), mem[k]);
  endtask

  task automatic run_flush();
    int waited;
    drain();
    flush_req++;
    flush_start_i = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    flush_start_i = 1'b0;
    waited = 0;
    while (flush_cnt < flush_req)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
      if (waited > TIMEOUT)
      begin
        errors++;
        $display("timeout, flush-all never signalled done");
        end_run();
      end
    end
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    check_value("flush_done_o pulses", flush_req, flush_cnt);
    compare_memory();
  endtask

  task automatic run_stimulus();
    int                fd;
    int                n;
    logic [7:0]        op;
    logic [31:0]       a_val;
    logic [31:0]       d_val;
    logic [31:0]       s_val;
    logic [8*128-1:0]  skip_line;
    bus_req_t          r;
    fd = $fopen("verification/cache_stim.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("cannot open the stimulus file");
    end
    else
    begin
      n = $fscanf(fd, "%s", op);
      while (n == 1)
      begin
        if (op == "#")
          n = $fgets(skip_line, fd);
        else
        begin
          n = $fscanf(fd, "%h %h %h", a_val, d_val, s_val);
          if (n != 3)
          begin
            errors++;
            $display("stimulus line for op %s is incomplete", op);
          end
          r          = '0;
          r.addr.raw = a_val;
          r.data     = d_val;
          r.we       = (op == "W");
          r.sel      = s_val[SEL_W-1:0];
          case (op)
            "R", "W": send_request(r);
            "F":      run_flush();
            default:
            begin
              errors++;
              $display("unknown op code %s in the stimulus file", op);
            end
          endcase
        end
        n = $fscanf(fd, "%s", op);
      end
      $fclose(fd);
    end
  endtask

  initial
  begin
    rst           = 1'b1;
    flush_start_i = 1'b0;
    bus_cyc_i     = 1'b0;
    bus_stb_i     = 1'b0;
    bus_req_i     = '0;
    dst_stall_i   = 1'b0;
    dst_ack_i     = 1'b0;
    dst_data_i    = '0;
    repeat (8)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      check_idle_outputs();
    end
    rst = 1'b0;
    @(negedge clk);
    check_idle_outputs();
    @(posedge clk);
    #DRIVE_DLY;
    run_stimulus();
    drain();
    check_value("bus_ack_o count", sent_cnt, ack_cnt);
    check_value("requests left without ack", 0, pend_q.size());
    end_run();
  end

endmodule

// ==== verilog/ddr3_cache.sv ====
module ddr3_cache (
  input  logic                             clk,
  input  logic                             rst,

  input  logic                             flush_start_i,
  output logic                             flush_done_o,

  input  logic                             bus_cyc_i,
  input  logic                             bus_stb_i,
  input  cache_pkg::bus_req_t              bus_req_i,
  output logic                             bus_stall_o,
  output logic                             bus_ack_o,
  output logic [cache_pkg::BUS_DATA_W-1:0] bus_data_o,

  output logic                             dst_cyc_o,
  output logic                             dst_stb_o,
  output cache_pkg::mem_req_t              dst_req_o,
  input  logic                             dst_stall_i,
  input  logic                             dst_ack_i,
  input  cache_pkg::line_data_t            dst_data_i
);

  import cache_pkg::*;

  logic                        push;
  logic                        pop;
  bus_req_t                    head_req;
  logic                        head_valid;
  logic [NUM_LINES-1:0]        hit;
  logic [NUM_LINES-1:0]        vld;
  logic [NUM_LINES-1:0]        dirty;
  tag_t [NUM_LINES-1:0]        tag;
  line_data_t [NUM_LINES-1:0]  data;
  logic [NUM_LINES-1:0]        line_sel;
  line_cmd_t                   cmd;
  logic                        touch;
  line_idx_t                   touch_idx;
  line_idx_t                   lru_idx;

  assign push = bus_cyc_i & bus_stb_i & ~bus_stall_o;

  req_fifo u_req_fifo (
    .clk     (clk),
    .rst     (rst),
    .push_i  (push),
    .req_i   (bus_req_i),
    .pop_i   (pop),
    .req_o   (head_req),
    .valid_o (head_valid),
    .stall_o (bus_stall_o)
  );

  ////////////////////
  // line array.
  for (genvar g = 0; g < NUM_LINES; g++)
  begin : g_line
    cache_line u_line (
      .clk         (clk),
      .rst         (rst),
      .req_i       (head_req),
      .req_valid_i (head_valid),
      .sel_i       (line_sel[g]),
      .cmd_i       (cmd),
      .hit_o       (hit[g]),
      .vld_o       (vld[g]),
      .dirty_o     (dirty[g]),
      .tag_o       (tag[g]),
      .data_o      (data[g])
    );
  end

  lru_tracker u_lru (
    .clk         (clk),
    .rst         (rst),
    .touch_i     (touch),
    .touch_idx_i (touch_idx),
    .lru_idx_o   (lru_idx)
  );

  cache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .req_i         (head_req),
    .req_valid_i   (head_valid),
    .pop_o         (pop),
    .hit_i         (hit),
    .vld_i         (vld),
    .dirty_i       (dirty),
    .tag_i         (tag),
    .data_i        (data),
    .line_sel_o    (line_sel),
    .cmd_o         (cmd),
    .touch_o       (touch),
    .touch_idx_o   (touch_idx),
    .lru_idx_i     (lru_idx),
    .flush_start_i (flush_start_i),
    .flush_done_o  (flush_done_o),
    .bus_ack_o     (bus_ack_o),
    .bus_data_o    (bus_data_o),
    .dst_stb_o     (dst_stb_o),
    .dst_cyc_o     (dst_cyc_o),
    .dst_req_o     (dst_req_o),
    .dst_stall_i   (dst_stall_i),
    .dst_ack_i     (dst_ack_i),
    .dst_data_i    (dst_data_i)
  );

endmodule

// ==== verilog/cache_ctrl.sv ====
module cache_ctrl (
  input  logic                                               clk,
  input  logic                                               rst,
  input  cache_pkg::bus_req_t                                req_i,
  input  logic                                               req_valid_i,
  output logic                                               pop_o,
  input  logic [cache_pkg::NUM_LINES-1:0]                    hit_i,
  input  logic [cache_pkg::NUM_LINES-1:0]                    vld_i,
  input  logic [cache_pkg::NUM_LINES-1:0]                    dirty_i,
  input  cache_pkg::tag_t [cache_pkg::NUM_LINES-1:0]         tag_i,
  input  cache_pkg::line_data_t [cache_pkg::NUM_LINES-1:0]   data_i,
  output logic [cache_pkg::NUM_LINES-1:0]                    line_sel_o,
  output cache_pkg::line_cmd_t                               cmd_o,
  output logic                                               touch_o,
  output cache_pkg::line_idx_t                               touch_idx_o,
  input  cache_pkg::line_idx_t                               lru_idx_i,
  input  logic                                               flush_start_i,
  output logic                                               flush_done_o,
  output logic                                               bus_ack_o,
  output logic [cache_pkg::BUS_DATA_W-1:0]                   bus_data_o,
  output logic                                               dst_stb_o,
  output logic                                               dst_cyc_o,
  output cache_pkg::mem_req_t                                dst_req_o,
  input  logic                                               dst_stall_i,
  input  logic                                               dst_ack_i,
  input  cache_pkg::line_data_t                              dst_data_i
);

  import cache_pkg::*;

  typedef struct packed {
    logic idle;
    logic writeback;
    logic load;
    logic load_wait;
    logic update;
    logic flushall;
  } state_t;

  state_t                st_q;
  state_t                st_d;
  line_idx_t             entry_q;
  line_idx_t             entry_d;
  line_idx_t             flush_idx_q;
  line_idx_t             flush_idx_d;
  line_idx_t             line_idx;
  line_idx_t             hit_idx;
  line_idx_t             victim_idx;
  logic                  line_wb;
  logic                  flush_step;
  logic                  flush_done_d;
  logic                  ack_d;
  bus_addr_u             wb_addr;
  bus_addr_u             ld_addr;
  logic [BUS_DATA_W-1:0] hit_word;
  logic [BUS_DATA_W-1:0] rd_word;

  ////////////////////
  // lookup.
  // lowest invalid line wins over the lru line.
  always_comb
  begin
    hit_idx    = '0;
    victim_idx = lru_idx_i;
    for (int i = NUM_LINES - 1; i >= 0; i--)
    begin
      if (hit_i[i])
        hit_idx = line_idx_t'(i);
      if (!vld_i[i])
        victim_idx = line_idx_t'(i);
    end
  end

  assign line_idx   = st_q.flushall ? flush_idx_q : entry_q;
  assign line_wb    = vld_i[line_idx] & dirty_i[line_idx];
  assign flush_step = ~line_wb | ~dst_stall_i;

  always_comb
  begin
    wb_addr.raw   = '0;
    wb_addr.f.tag = tag_i[line_idx];
    ld_addr.raw   = '0;
    ld_addr.f.tag = req_i.addr.f.tag;
  end

  // unselected bytes read back as zero.
  always_comb
  begin
    hit_word = data_i[entry_q][req_i.addr.f.word];
    for (int b = 0; b < SEL_W; b++)
      rd_word[8*b +: 8] = req_i.sel[b] ? hit_word[8*b +: 8] : 8'h00;
  end

  ////////////////////
  // state machine.
  always_comb
  begin
    st_d         = '0;
    entry_d      = entry_q;
    flush_idx_d  = flush_idx_q;
    flush_done_d = 1'b0;
    ack_d        = 1'b0;
    cmd_o        = '0;
    dst_stb_o    = 1'b0;
    dst_req_o    = '0;
    case (1'b1)
      st_q.idle:
      begin
        if (flush_start_i)
        begin
          flush_idx_d   = '0;
          st_d.flushall = 1'b1;
        end
        else if (req_valid_i && |hit_i)
        begin
          entry_d     = hit_idx;
          st_d.update = 1'b1;
        end
        else if (req_valid_i)
        begin
          entry_d        = victim_idx;
          st_d.writeback = vld_i[victim_idx] & dirty_i[victim_idx];
          st_d.load      = ~(vld_i[victim_idx] & dirty_i[victim_idx]);
        end
        else
          st_d.idle = 1'b1;
      end
      st_q.writeback:
      begin
        dst_stb_o      = 1'b1;
        dst_req_o.addr = wb_addr.raw;
        dst_req_o.data = data_i[line_idx];
        dst_req_o.we   = 1'b1;
        cmd_o.op       = dst_stall_i ? LINE_NONE : LINE_CLEAN;
        st_d.writeback = dst_stall_i;
        st_d.load      = ~dst_stall_i;
      end
      st_q.load:
      begin
        dst_stb_o      = 1'b1;
        dst_req_o.addr = ld_addr.raw;
        st_d.load      = dst_stall_i;
        st_d.load_wait = ~dst_stall_i;
      end
      st_q.load_wait:
      begin
        if (dst_ack_i)
        begin
          cmd_o.op    = LINE_FILL;
          cmd_o.tag   = req_i.addr.f.tag;
          cmd_o.data  = dst_data_i;
          st_d.update = 1'b1;
        end
        else
          st_d.load_wait = 1'b1;
      end
      st_q.update:
      begin
        ack_d       = 1'b1;
        cmd_o.op    = req_i.we ? LINE_WRITE : LINE_NONE;
        cmd_o.word  = req_i.addr.f.word;
        cmd_o.wdata = req_i.data;
        cmd_o.sel   = req_i.sel;
        st_d.idle   = 1'b1;
      end
      st_q.flushall:
      begin
        // only valid dirty lines go out, clean ones are skipped.
        dst_stb_o      = line_wb;
        dst_req_o.addr = wb_addr.raw;
        dst_req_o.data = data_i[line_idx];
        dst_req_o.we   = 1'b1;
        if (line_wb && !dst_stall_i)
          cmd_o.op = LINE_CLEAN;
        if (flush_step && flush_idx_q == line_idx_t'(NUM_LINES - 1))
        begin
          flush_done_d = 1'b1;
          st_d.idle    = 1'b1;
        end
        else
        begin
          if (flush_step)
            flush_idx_d = flush_idx_q + line_idx_t'(1);
          st_d.flushall = 1'b1;
        end
      end
      default: st_d.idle = 1'b1;
    endcase
  end

  always_comb
  begin
    line_sel_o = '0;
    if (cmd_o.op != LINE_NONE)
      line_sel_o[line_idx] = 1'b1;
  end

  // the request stays at the head until its update cycle.
  assign pop_o       = st_q.update;
  assign touch_o     = st_q.update;
  assign touch_idx_o = entry_q;
  assign dst_cyc_o   = dst_stb_o | st_q.load_wait;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      st_q         <= '{idle: 1'b1, default: 1'b0};
      entry_q      <= '0;
      flush_idx_q  <= '0;
      flush_done_o <= 1'b0;
      bus_ack_o    <= 1'b0;
    end
    else
    begin
      st_q         <= st_d;
      entry_q      <= entry_d;
      flush_idx_q  <= flush_idx_d;
      flush_done_o <= flush_done_d;
      bus_ack_o    <= ack_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ack_d)
      bus_data_o <= rd_word;
  end

endmodule

// ==== verilog/lru_tracker.sv ====
module lru_tracker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 touch_i,
  input  cache_pkg::line_idx_t touch_idx_i,
  output cache_pkg::line_idx_t lru_idx_o
);

  import cache_pkg::*;

  line_idx_t ages_q [NUM_LINES];
  line_idx_t ages_d [NUM_LINES];
  line_idx_t lru_d;

  // touched line becomes youngest, the ones younger than it move up by one.
  always_comb
  begin
    for (int i = 0; i < NUM_LINES; i++)
    begin
      ages_d[i] = ages_q[i];
      if (touch_i)
      begin
        if (line_idx_t'(i) == touch_idx_i)
          ages_d[i] = '0;
        else if (ages_q[i] < ages_q[touch_idx_i])
          ages_d[i] = ages_q[i] + line_idx_t'(1);
      end
    end
  end

  // oldest line of the next ages.
  always_comb
  begin
    lru_d = '0;
    for (int i = 1; i < NUM_LINES; i++)
    begin
      if (ages_d[i] > ages_d[lru_d])
        lru_d = line_idx_t'(i);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_LINES; i++)
        ages_q[i] <= line_idx_t'(i);
      lru_idx_o <= line_idx_t'(NUM_LINES - 1);
    end
    else
    begin
      for (int i = 0; i < NUM_LINES; i++)
        ages_q[i] <= ages_d[i];
      lru_idx_o <= lru_d;
    end
  end

endmodule

// ==== verilog/cache_line.sv ====
module cache_line (
  input  logic                  clk,
  input  logic                  rst,
  input  cache_pkg::bus_req_t   req_i,
  input  logic                  req_valid_i,
  input  logic                  sel_i,
  input  cache_pkg::line_cmd_t  cmd_i,
  output logic                  hit_o,
  output logic                  vld_o,
  output logic                  dirty_o,
  output cache_pkg::tag_t       tag_o,
  output cache_pkg::line_data_t data_o
);

  import cache_pkg::*;

  logic       vld_q;
  logic       dirty_q;
  tag_t       tag_q;
  line_data_t data_q;

  ////////////////////
  // state bits.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      vld_q   <= 1'b0;
      dirty_q <= 1'b0;
    end
    else if (sel_i)
    begin
      case (cmd_i.op)
        LINE_FILL:
        begin
          vld_q   <= 1'b1;
          dirty_q <= 1'b0;
        end
        LINE_WRITE: dirty_q <= 1'b1;
        LINE_CLEAN: dirty_q <= 1'b0;
        default:    dirty_q <= dirty_q;
      endcase
    end
  end

  ////////////////////
  // tag and data.
  always_ff @(posedge clk)
  begin
    if (sel_i && cmd_i.op == LINE_FILL)
    begin
      tag_q  <= cmd_i.tag;
      data_q <= cmd_i.data;
    end
    else if (sel_i && cmd_i.op == LINE_WRITE)
    begin
      // byte merge into the addressed word.
      for (int b = 0; b < SEL_W; b++)
      begin
        if (cmd_i.sel[b])
          data_q[cmd_i.word][8*b +: 8] <= cmd_i.wdata[8*b +: 8];
      end
    end
  end

  assign hit_o   = req_valid_i & vld_q & (tag_q == req_i.addr.f.tag);
  assign vld_o   = vld_q;
  assign dirty_o = dirty_q;
  assign tag_o   = tag_q;
  assign data_o  = data_q;

endmodule

// ==== verilog/req_fifo.sv ====
module req_fifo (
  input  logic                clk,
  input  logic                rst,
  input  logic                push_i,
  input  cache_pkg::bus_req_t req_i,
  input  logic                pop_i,
  output cache_pkg::bus_req_t req_o,
  output logic                valid_o,
  output logic                stall_o
);

  import cache_pkg::*;

  bus_req_t              mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  do_pop;

  assign do_pop = pop_i & valid_o;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= wr_ptr_q + FIFO_PTR_W'(1);
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + FIFO_PTR_W'(1);
      count_q <= count_q + FIFO_CNT_W'(push_i) - FIFO_CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push_i)
      mem_q[wr_ptr_q] <= req_i;
  end

  assign req_o   = mem_q[rd_ptr_q];
  assign valid_o = (count_q != '0);
  // one entry early, leaves room for a request already on its way.
  assign stall_o = (count_q >= FIFO_CNT_W'(FIFO_DEPTH - 1));

endmodule

// ==== verilog/cache_pkg.sv ====
package cache_pkg;

  ////////////////////
  // sizes.
  localparam int NUM_LINES      = 32;
  localparam int LINE_IDX_W     = 5;
  localparam int WORDS_PER_LINE = 4;
  localparam int BUS_ADDR_W     = 32;
  localparam int BUS_DATA_W     = 32;
  localparam int SEL_W          = 4;
  localparam int MEM_DATA_W     = 128;
  localparam int TAG_W          = 22;
  localparam int FIFO_DEPTH     = 4;

  localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE);
  localparam int BYTE_OFS_W = $clog2(SEL_W);
  localparam int ADDR_PAD_W = BUS_ADDR_W - TAG_W - WORD_IDX_W - BYTE_OFS_W;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  ////////////////////
  // types.
  typedef logic [LINE_IDX_W-1:0] line_idx_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [WORDS_PER_LINE-1:0][MEM_DATA_W/WORDS_PER_LINE-1:0] line_data_t;

  typedef struct packed {
    logic [ADDR_PAD_W-1:0] unused;
    tag_t                  tag;
    logic [WORD_IDX_W-1:0] word;
    logic [BYTE_OFS_W-1:0] byte_ofs;
  } bus_addr_fields_t;

  // raw word on the bus, fields for the lookup.
  typedef union packed {
    logic [BUS_ADDR_W-1:0] raw;
    bus_addr_fields_t      f;
  } bus_addr_u;

  typedef struct packed {
    bus_addr_u             addr;
    logic [BUS_DATA_W-1:0] data;
    logic                  we;
    logic [SEL_W-1:0]      sel;
  } bus_req_t;

  typedef struct packed {
    logic [BUS_ADDR_W-1:0] addr;
    line_data_t            data;
    logic                  we;
  } mem_req_t;

  typedef enum logic [1:0] {
    LINE_NONE  = 2'd0,
    LINE_FILL  = 2'd1,
    LINE_WRITE = 2'd2,
    LINE_CLEAN = 2'd3
  } line_op_e;

  typedef struct packed {
    line_op_e              op;
    tag_t                  tag;
    line_data_t            data;
    logic [WORD_IDX_W-1:0] word;
    logic [BUS_DATA_W-1:0] wdata;
    logic [SEL_W-1:0]      sel;
  } line_cmd_t;

endpackage
